// ==== filelist.f ====
source/memPkg.sv
source/memL2Ctrl.sv
source/l2LineStore.sv
source/extMemArray.sv
source/mmioGpio.sv
source/memSubsystem.sv
tests/tbClock.sv
tests/memChecker.sv
tests/memSubsystemTb.sv

// ==== source/extMemArray.sv ====
`default_nettype none

module extMemArray (
	input wire clock,
	input wire rstN,
	input wire memPkg::extReq_s req,
	output logic done,
	output logic [memPkg::lineBits-1:0] lineOut
);

	localparam int cntBits = $clog2(memPkg::extDelay + 1);

	logic [memPkg::lineBits-1:0] mem [memPkg::memLines];
	logic [cntBits-1:0] delayCnt;
	logic [memPkg::lineBits-1:0] lineReg;

	// zeroed at reset and written at the strobe
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < memPkg::memLines; i++)
				mem[i] <= '0;
		end
		else if (req.strobe && req.write)
			mem[req.line] <= req.data;
	end

	// line read at the strobe
	always_ff @(posedge clock)
	begin
		if (req.strobe && !req.write)
			lineReg <= mem[req.line];
	end

	// counts down from extDelay after the strobe
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			delayCnt <= '0;
		else if (req.strobe)
			delayCnt <= cntBits'(memPkg::extDelay);
		else if (delayCnt != '0)
			delayCnt <= delayCnt - 1'b1;
	end

	// last count is extDelay cycles after the strobe
	assign done = delayCnt == cntBits'(1);
	assign lineOut = lineReg;

endmodule

`default_nettype wire

// ==== source/l2LineStore.sv ====
`default_nettype none

module l2LineStore (
	input wire clock,
	input wire rstN,
	input wire [memPkg::indexBits-1:0] index,
	input wire we,
	input wire [memPkg::tagBits-1:0] tagIn,
	input wire [memPkg::lineBits-1:0] lineIn,
	output logic [memPkg::tagBits-1:0] tagOut,
	output logic validOut,
	output logic [memPkg::lineBits-1:0] lineOut
);

	// tag and data arrays
	logic [memPkg::tagBits-1:0] tagMem [memPkg::cacheLines];
	logic [memPkg::lineBits-1:0] lineMem [memPkg::cacheLines];
	// one valid bit per line
	logic [memPkg::cacheLines-1:0] validBits;

	// asynchronous read of the indexed entry
	assign tagOut = tagMem[index];
	assign lineOut = lineMem[index];
	assign validOut = validBits[index];

	// synchronous write of tag and line
	always_ff @(posedge clock)
	begin
		if (we)
		begin
			tagMem[index] <= tagIn;
			lineMem[index] <= lineIn;
		end
	end

	// valid bits cleared on reset, set by any write
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			validBits <= '0;
		else if (we)
			validBits[index] <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== source/memL2Ctrl.sv ====
`default_nettype none

module memL2Ctrl (
	input wire clock,
	input wire rstN,
	input wire memPkg::memReq_s req,
	output memPkg::memRsp_s rsp,
	output logic [memPkg::indexBits-1:0] cacheIndex,
	output logic cacheWe,
	output logic [memPkg::tagBits-1:0] cacheTag,
	output logic [memPkg::lineBits-1:0] cacheLine,
	input wire [memPkg::tagBits-1:0] storedTag,
	input wire storedValid,
	input wire [memPkg::lineBits-1:0] storedLine,
	output memPkg::extReq_s ext,
	input wire extDone,
	input wire [memPkg::lineBits-1:0] extLine,
	output memPkg::mmioReq_s mmio,
	input wire mmioDone,
	input wire [31:0] mmioData,
	input wire mmioFault
);

	// fsm states
	localparam logic [2:0] idle = 3'd0;
	localparam logic [2:0] lookup = 3'd1;
	localparam logic [2:0] waitExt = 3'd2;
	localparam logic [2:0] waitMmio = 3'd3;
	localparam logic [2:0] reply = 3'd4;

	logic [2:0] state;
	logic [2:0] nextState;
	logic [memPkg::lineBits-1:0] replyLine;
	logic isLoad;
	logic isStore;
	logic validOp;
	logic isMmio;
	logic hit;

	// request decode, request is held steady by the requester
	assign isLoad = req.opm == memPkg::opLoad;
	assign isStore = req.opm == memPkg::opStore;
	assign validOp = isLoad || isStore;
	assign isMmio = req.addr.regs.region == memPkg::mmioRegion;
	// tag compare against the indexed line
	assign hit = storedValid && (storedTag == req.addr.line.tag);

	// cache side
	assign cacheIndex = req.addr.line.index;
	assign cacheTag = req.addr.line.tag;
	// fill on load miss, refresh with store data on store hit
	assign cacheLine = isLoad ? extLine : req.wdata;
	assign cacheWe = (state == waitExt) && extDone && (isLoad || hit);

	// backing store, one strobe per miss or store
	always_comb
	begin
		ext.strobe = (state == lookup) && validOp && !isMmio && (isStore || !hit);
		ext.write = isStore;
		ext.line = {req.addr.line.tag, req.addr.line.index};
		ext.data = req.wdata;
	end

	// mmio side gets only the low word
	always_comb
	begin
		mmio.strobe = (state == lookup) && validOp && isMmio;
		mmio.write = isStore;
		mmio.regSel = req.addr.regs.regSel;
		mmio.data = req.wdata[31:0];
	end

	always_comb
	begin
		nextState = state;
		case (state)
			idle:
				if (req.opm != memPkg::opNone)
					nextState = lookup;
			lookup:
			begin
				if (!validOp)
					nextState = idle;
				else if (isMmio)
					nextState = waitMmio;
				// load hit finishes right here
				else if (isLoad && hit)
					nextState = idle;
				else
					nextState = waitExt;
			end
			waitExt:
				if (extDone)
					nextState = reply;
			waitMmio:
				if (mmioDone)
					nextState = idle;
			reply:
				nextState = idle;
			default:
				nextState = idle;
		endcase
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			state <= idle;
		else
			state <= nextState;
	end

	// line returned in reply, stores give zero data
	always_ff @(posedge clock)
	begin
		if (state == waitExt && extDone)
			replyLine <= isLoad ? extLine : '0;
	end

	// status back to the requester, ok or fault for one cycle only
	always_comb
	begin
		rsp.ok = memPkg::okReady;
		rsp.rdata = '0;
		case (state)
			lookup:
			begin
				if (!validOp)
					rsp.ok = memPkg::okFault;
				else if (!isMmio && isLoad && hit)
				begin
					rsp.ok = memPkg::okOk;
					rsp.rdata = storedLine;
				end
				else
					rsp.ok = memPkg::okHold;
			end
			waitExt:
				rsp.ok = memPkg::okHold;
			waitMmio:
			begin
				if (mmioDone)
				begin
					rsp.ok = mmioFault ? memPkg::okFault : memPkg::okOk;
					// zero extended register word
					rsp.rdata = memPkg::lineBits'(mmioData);
				end
				else
					rsp.ok = memPkg::okHold;
			end
			reply:
			begin
				rsp.ok = memPkg::okOk;
				rsp.rdata = replyLine;
			end
			default:
				rsp.ok = memPkg::okReady;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/memPkg.sv ====
`default_nettype none

package memPkg;

	// bus widths
	localparam int lineBits = 128;
	localparam int addrBits = 32;
	localparam int opmBits = 5;

	// operation codes, held non-zero until the status reads OK
	localparam logic [opmBits-1:0] opNone = 5'h00;
	localparam logic [opmBits-1:0] opLoad = 5'h01;
	localparam logic [opmBits-1:0] opStore = 5'h02;

	// status codes
	localparam logic [1:0] okReady = 2'b00;
	localparam logic [1:0] okOk = 2'b01;
	localparam logic [1:0] okHold = 2'b10;
	localparam logic [1:0] okFault = 2'b11;

	// top three address bits that select the mmio space
	localparam logic [2:0] mmioRegion = 3'b101;

	// cache and backing store geometry
	localparam int cacheLines = 16;
	localparam int memLines = 256;
	localparam int extDelay = 4;
	localparam int indexBits = $clog2(cacheLines);
	localparam int tagBits = $clog2(memLines) - indexBits;
	localparam int lineNumBits = $clog2(memLines);
	localparam int offsetBits = 4;
	localparam int regSelBits = 4;

	// gpio register selects
	localparam logic [regSelBits-1:0] gpioRegOut = 4'd0;
	localparam logic [regSelBits-1:0] gpioRegDir = 4'd1;
	localparam logic [regSelBits-1:0] gpioRegIn = 4'd2;

	// address as seen by the line cache
	typedef struct packed {
		logic [2:0] region;
		logic [addrBits-3-tagBits-indexBits-offsetBits-1:0] spare;
		logic [tagBits-1:0] tag;
		logic [indexBits-1:0] index;
		logic [offsetBits-1:0] offset;
	} lineView_s;

	// address as seen by an mmio block
	typedef struct packed {
		logic [2:0] region;
		logic [addrBits-3-regSelBits-offsetBits-1:0] spare;
		logic [regSelBits-1:0] regSel;
		logic [offsetBits-1:0] wordOff;
	} regView_s;

	typedef union packed {
		lineView_s line;
		regView_s regs;
	} memAddr_u;

	typedef struct packed {
		logic [opmBits-1:0] opm;
		memAddr_u addr;
		logic [lineBits-1:0] wdata;
	} memReq_s;

	typedef struct packed {
		logic [1:0] ok;
		logic [lineBits-1:0] rdata;
	} memRsp_s;

	typedef struct packed {
		logic strobe;
		logic write;
		logic [lineNumBits-1:0] line;
		logic [lineBits-1:0] data;
	} extReq_s;

	typedef struct packed {
		logic strobe;
		logic write;
		logic [regSelBits-1:0] regSel;
		logic [31:0] data;
	} mmioReq_s;

endpackage

`default_nettype wire

// ==== source/memSubsystem.sv ====
`default_nettype none

module memSubsystem (
	input wire clock,
	input wire rstN,
	input wire memPkg::memReq_s req,
	output memPkg::memRsp_s rsp,
	input wire [31:0] gpioIn,
	output logic [31:0] gpioOut,
	output logic [31:0] gpioDir
);

	// controller to cache
	logic [memPkg::indexBits-1:0] cacheIndex;
	logic cacheWe;
	logic [memPkg::tagBits-1:0] cacheTag;
	logic [memPkg::lineBits-1:0] cacheLine;
	logic [memPkg::tagBits-1:0] storedTag;
	logic storedValid;
	logic [memPkg::lineBits-1:0] storedLine;

	// controller to backing store
	memPkg::extReq_s extReq;
	logic extDone;
	logic [memPkg::lineBits-1:0] extLine;

	// controller to gpio
	memPkg::mmioReq_s mmioReq;
	logic mmioDone;
	logic [31:0] mmioData;
	logic mmioFault;

	memL2Ctrl u_memL2Ctrl (
		.clock(clock),
		.rstN(rstN),
		.req(req),
		.rsp(rsp),
		.cacheIndex(cacheIndex),
		.cacheWe(cacheWe),
		.cacheTag(cacheTag),
		.cacheLine(cacheLine),
		.storedTag(storedTag),
		.storedValid(storedValid),
		.storedLine(storedLine),
		.ext(extReq),
		.extDone(extDone),
		.extLine(extLine),
		.mmio(mmioReq),
		.mmioDone(mmioDone),
		.mmioData(mmioData),
		.mmioFault(mmioFault)
	);

	l2LineStore u_l2LineStore (
		.clock(clock),
		.rstN(rstN),
		.index(cacheIndex),
		.we(cacheWe),
		.tagIn(cacheTag),
		.lineIn(cacheLine),
		.tagOut(storedTag),
		.validOut(storedValid),
		.lineOut(storedLine)
	);

	// stands in for the ddr controller
	extMemArray u_extMemArray (
		.clock(clock),
		.rstN(rstN),
		.req(extReq),
		.done(extDone),
		.lineOut(extLine)
	);

	mmioGpio u_mmioGpio (
		.clock(clock),
		.rstN(rstN),
		.req(mmioReq),
		.done(mmioDone),
		.rdata(mmioData),
		.fault(mmioFault),
		.gpioIn(gpioIn),
		.gpioOut(gpioOut),
		.gpioDir(gpioDir)
	);

endmodule

`default_nettype wire

// ==== source/mmioGpio.sv ====
`default_nettype none

module mmioGpio (
	input wire clock,
	input wire rstN,
	input wire memPkg::mmioReq_s req,
	output logic done,
	output logic [31:0] rdata,
	output logic fault,
	input wire [31:0] gpioIn,
	output logic [31:0] gpioOut,
	output logic [31:0] gpioDir
);

	logic [31:0] outReg;
	logic [31:0] dirReg;
	// two flop synchronizer, second stage is the input register
	logic [31:0] inSync;
	logic [31:0] inReg;

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			inSync <= '0;
			inReg <= '0;
		end
		else
		begin
			inSync <= gpioIn;
			inReg <= inSync;
		end
	end

	// register access, answered one cycle after the strobe
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			outReg <= '0;
			dirReg <= '0;
			done <= 1'b0;
			fault <= 1'b0;
			rdata <= '0;
		end
		else
		begin
			done <= req.strobe;
			fault <= 1'b0;
			rdata <= '0;
			if (req.strobe)
			begin
				case (req.regSel)
					memPkg::gpioRegOut:
						if (req.write)
							outReg <= req.data;
						else
							rdata <= outReg;
					memPkg::gpioRegDir:
						if (req.write)
							dirReg <= req.data;
						else
							rdata <= dirReg;
					// input register is read only
					memPkg::gpioRegIn:
						if (req.write)
							fault <= 1'b1;
						else
							rdata <= inReg;
					// unmapped select
					default:
						fault <= 1'b1;
				endcase
			end
		end
	end

	assign gpioOut = outReg;
	assign gpioDir = dirReg;

endmodule

`default_nettype wire

// ==== tests/memChecker.sv ====
`default_nettype none

module memChecker (
	input wire clock,
	input wire rstN,
	input wire memPkg::memReq_s req,
	input wire memPkg::memRsp_s rsp,
	input wire [31:0] gpioIn,
	input wire [31:0] gpioOut,
	input wire [31:0] gpioDir,
	output int errorCount,
	output int checkCount,
	output int respCount
);

	timeunit 1ns;
	timeprecision 1ps;

	// shadow of backing lines and gpio registers
	logic [memPkg::lineBits-1:0] memShadow [memPkg::memLines];
	logic [31:0] outShadow;
	logic [31:0] dirShadow;
	// gpioIn as last seen at a completed request
	logic [31:0] inShadow;
	// request already on the bus at the previous falling edge
	logic requestSeen;
	memPkg::memRsp_s expected;

	initial
	begin
		for (int i = 0; i < memPkg::memLines; i++)
			memShadow[i] = '0;
		outShadow = '0;
		dirShadow = '0;
		inShadow = '0;
		requestSeen = 1'b0;
		errorCount = 0;
		checkCount = 0;
		respCount = 0;
	end

	// expected status and read data from the shadow
	function automatic memPkg::memRsp_s expectedResponse(input memPkg::memReq_s r);
		memPkg::memRsp_s e;
		logic isLoad;
		logic [7:0] lineNum;
		isLoad = r.opm == memPkg::opLoad;
		lineNum = {r.addr.line.tag, r.addr.line.index};
		e.ok = memPkg::okOk;
		e.rdata = '0;
		if (r.opm != memPkg::opLoad && r.opm != memPkg::opStore)
			e.ok = memPkg::okFault;
		else if (r.addr.regs.region == memPkg::mmioRegion)
		begin
			// register word comes back zero extended
			case (r.addr.regs.regSel)
				4'd0:
					if (isLoad)
						e.rdata = {96'b0, outShadow};
				4'd1:
					if (isLoad)
						e.rdata = {96'b0, dirShadow};
				4'd2:
					if (isLoad)
						e.rdata = {96'b0, inShadow};
					else
						e.ok = memPkg::okFault;
				default:
					e.ok = memPkg::okFault;
			endcase
		end
		// stores answer with zero data
		else if (isLoad)
			e.rdata = memShadow[lineNum];
		return e;
	endfunction

	task automatic applyStore(input memPkg::memReq_s r);
		if (r.addr.regs.region != memPkg::mmioRegion)
			memShadow[{r.addr.line.tag, r.addr.line.index}] = r.wdata;
		else if (r.addr.regs.regSel == 4'd0)
			outShadow = r.wdata[31:0];
		else if (r.addr.regs.regSel == 4'd1)
			dirShadow = r.wdata[31:0];
	endtask

	task automatic reportHex(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		errorCount++;
		$display("** Error %s: expected %h, got %h at %0t", name, exp, act, $time);
	endtask

	// outputs settle by the falling edge
	always @(negedge clock)
	begin
		if (rstN)
		begin
			if (rsp.ok == memPkg::okOk || rsp.ok == memPkg::okFault)
			begin
				respCount++;
				if (req.opm == memPkg::opNone)
				begin
					errorCount++;
					$display("a response came with no request pending at %0t", $time);
				end
				else
				begin
					expected = expectedResponse(req);
					checkCount += 2;
					if (rsp.ok != expected.ok)
						reportHex("rsp.ok", 128'(expected.ok), 128'(rsp.ok));
					if (rsp.rdata != expected.rdata)
						reportHex("rsp.rdata", expected.rdata, rsp.rdata);
					if (expected.ok == memPkg::okOk && req.opm == memPkg::opStore)
						applyStore(req);
				end
				// input register has caught up by now
				inShadow = gpioIn;
				requestSeen = 1'b0;
			end
			// idle between requests
			else if (req.opm == memPkg::opNone)
			begin
				checkCount++;
				if (rsp.ok != memPkg::okReady)
					reportHex("rsp.ok", 128'(memPkg::okReady), 128'(rsp.ok));
			end
			// busy once the controller has taken the request
			else
			begin
				if (requestSeen)
				begin
					checkCount++;
					if (rsp.ok != memPkg::okHold)
						reportHex("rsp.ok", 128'(memPkg::okHold), 128'(rsp.ok));
				end
				requestSeen = 1'b1;
			end
			// gpio outputs move only on a completed store
			checkCount += 2;
			if (gpioOut != outShadow)
				reportHex("gpioOut", 128'(outShadow), 128'(gpioOut));
			if (gpioDir != dirShadow)
				reportHex("gpioDir", 128'(dirShadow), 128'(gpioDir));
		end
	end

endmodule

`default_nettype wire

// ==== tests/memSubsystemTb.sv ====
`default_nettype none

module memSubsystemTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int resetCycles = 16;
	localparam int directedRequests = 48;
	localparam int randomRequests = 200;
	// store or miss plus one idle cycle is the longest request
	localparam int timeoutLimit = (directedRequests + randomRequests) * (memPkg::extDelay + 4)
		+ resetCycles + 100;

	logic clock;
	logic rstN;
	memPkg::memReq_s req;
	memPkg::memRsp_s rsp;
	logic [31:0] gpioIn;
	logic [31:0] gpioOut;
	logic [31:0] gpioDir;
	int errorCount;
	int checkCount;
	int respCount;
	int requestCount;
	int localErrors;
	int cycleCount;
	logic [31:0] rngState;

	tbClock u_tbClock (
		.clock(clock)
	);

	memSubsystem u_memSubsystem (
		.clock(clock),
		.rstN(rstN),
		.req(req),
		.rsp(rsp),
		.gpioIn(gpioIn),
		.gpioOut(gpioOut),
		.gpioDir(gpioDir)
	);

	memChecker u_memChecker (
		.clock(clock),
		.rstN(rstN),
		.req(req),
		.rsp(rsp),
		.gpioIn(gpioIn),
		.gpioOut(gpioOut),
		.gpioDir(gpioDir),
		.errorCount(errorCount),
		.checkCount(checkCount),
		.respCount(respCount)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic drawWord(output logic [31:0] w);
		rngState = xorshift32(rngState);
		w = rngState;
	endtask

	task automatic drawLine(output logic [127:0] l);
		logic [31:0] w;
		for (int i = 0; i < 4; i++)
		begin
			drawWord(w);
			l[i*32 +: 32] = w;
		end
	endtask

	// memory address of backing line lineNum
	function automatic memPkg::memAddr_u lineAddr(input logic [7:0] lineNum);
		memPkg::memAddr_u a;
		a = '0;
		a.line.tag = lineNum[7:4];
		a.line.index = lineNum[3:0];
		return a;
	endfunction

	function automatic memPkg::memAddr_u regAddr(input logic [3:0] sel);
		memPkg::memAddr_u a;
		a = '0;
		a.regs.region = memPkg::mmioRegion;
		a.regs.regSel = sel;
		return a;
	endfunction

	// drive one request and hold it until ok or fault, then one idle cycle
	task automatic issueRequest(input logic [memPkg::opmBits-1:0] opm,
		input memPkg::memAddr_u addr, input logic [127:0] wdata);
		memPkg::memReq_s r;
		r.opm = opm;
		r.addr = addr;
		r.wdata = wdata;
		@(posedge clock);
		req <= r;
		requestCount++;
		@(negedge clock);
		while (rsp.ok != memPkg::okOk && rsp.ok != memPkg::okFault)
			@(negedge clock);
		@(posedge clock);
		req.opm <= memPkg::opNone;
	endtask

	task automatic runRandom(input int count);
		logic [31:0] pick;
		logic [127:0] data;
		logic [memPkg::opmBits-1:0] badOp;
		for (int n = 0; n < count; n++)
		begin
			drawWord(pick);
			drawLine(data);
			// anything from 3 up to 31
			badOp = 5'(3 + (pick[20:16] % 29));
			case (pick[2:0])
				3'd0, 3'd1, 3'd2:
					issueRequest(memPkg::opLoad, lineAddr(pick[12:8]), data);
				3'd3, 3'd4, 3'd5:
					issueRequest(memPkg::opStore, lineAddr(pick[12:8]), data);
				3'd6:
					issueRequest(pick[3] ? memPkg::opStore : memPkg::opLoad,
						regAddr({1'b0, pick[6:4]}), data);
				default:
					issueRequest(badOp,
						pick[3] ? regAddr(pick[7:4]) : lineAddr(pick[12:8]), data);
			endcase
		end
	endtask

	initial
	begin : stimulus
		logic [127:0] dataA;
		logic [127:0] dataB;
		logic [31:0] word;
		req = '0;
		gpioIn = '0;
		rstN = 1'b0;
		rngState = 32'haeaabb48;
		requestCount = 0;
		localErrors = 0;
		repeat (resetCycles) @(posedge clock);
		rstN <= 1'b1;

		// untouched lines read as zero
		issueRequest(memPkg::opLoad, lineAddr(0), '0);
		issueRequest(memPkg::opLoad, lineAddr(17), '0);
		issueRequest(memPkg::opLoad, lineAddr(31), '0);

		// store, miss fill, then hit
		for (int k = 0; k < 4; k++)
		begin
			drawLine(dataA);
			issueRequest(memPkg::opStore, lineAddr(3 + 3 * k), dataA);
			issueRequest(memPkg::opLoad, lineAddr(3 + 3 * k), '0);
			issueRequest(memPkg::opLoad, lineAddr(3 + 3 * k), '0);
		end

		// lines 7 and 23 share index 7
		drawLine(dataA);
		drawLine(dataB);
		issueRequest(memPkg::opStore, lineAddr(7), dataA);
		issueRequest(memPkg::opStore, lineAddr(23), dataB);
		for (int k = 0; k < 3; k++)
		begin
			issueRequest(memPkg::opLoad, lineAddr(7), '0);
			issueRequest(memPkg::opLoad, lineAddr(23), '0);
			drawLine(dataA);
			issueRequest(memPkg::opStore, lineAddr(k[0] ? 7 : 23), dataA);
		end

		// gpio output and direction, upper data bits must not leak back
		drawLine(dataA);
		issueRequest(memPkg::opStore, regAddr(0), dataA);
		issueRequest(memPkg::opLoad, regAddr(0), '0);
		drawLine(dataB);
		issueRequest(memPkg::opStore, regAddr(1), dataB);
		issueRequest(memPkg::opLoad, regAddr(1), '0);

		// gpioIn held from here on
		drawWord(word);
		@(posedge clock);
		gpioIn <= word;
		issueRequest(memPkg::opLoad, lineAddr(7), '0);
		issueRequest(memPkg::opLoad, regAddr(2), '0);
		// read only and unmapped selects
		drawLine(dataA);
		issueRequest(memPkg::opStore, regAddr(2), dataA);
		issueRequest(memPkg::opLoad, regAddr(3), '0);
		issueRequest(memPkg::opStore, regAddr(4), dataA);
		issueRequest(memPkg::opLoad, regAddr(15), '0);
		issueRequest(memPkg::opStore, regAddr(9), dataA);
		issueRequest(memPkg::opLoad, regAddr(0), '0);
		issueRequest(memPkg::opLoad, regAddr(1), '0);

		// unknown opcodes touch nothing
		drawLine(dataA);
		issueRequest(5'd3, lineAddr(7), dataA);
		issueRequest(5'd31, lineAddr(23), dataA);
		issueRequest(5'd4, regAddr(0), dataA);
		issueRequest(5'd16, regAddr(1), dataA);
		issueRequest(memPkg::opLoad, lineAddr(7), '0);
		issueRequest(memPkg::opLoad, lineAddr(23), '0);
		issueRequest(memPkg::opLoad, regAddr(0), '0);
		issueRequest(memPkg::opLoad, regAddr(1), '0);

		runRandom(randomRequests);
		repeat (4) @(posedge clock);

		if (respCount != requestCount)
		begin
			localErrors++;
			$display("saw %0d responses for %0d requests", respCount, requestCount);
		end
		$display("closing: %0d errors in %0d checks over %0d requests",
			errorCount + localErrors, checkCount, requestCount);
		if (errorCount + localErrors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// run limit in cycles
	initial
	begin
		cycleCount = 0;
		while (cycleCount < timeoutLimit)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("run timed out after %0d cycles with %0d requests issued",
			cycleCount, requestCount);
		$display("closing: %0d errors in %0d checks over %0d requests",
			errorCount + localErrors + 1, checkCount, requestCount);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/tbClock.sv ====
`default_nettype none

module tbClock (
	output logic clock
);

	timeunit 1ns;
	timeprecision 1ps;

	// 8 ns period
	localparam int halfPeriod = 4;

	initial
	begin
		clock = 1'b0;
		forever
			#halfPeriod clock = ~clock;
	end

endmodule

`default_nettype wire
